/* flist.f */
cache_pkg.sv
cache_csr_pkg.sv
cache_lookup.sv
cache_access.sv
cache_wtbuf.sv
cache_control.sv
cache_top.sv
tb_cache_top.sv

/* Bender.yml */
package:
  name: cache_wt

sources:
  - cache_pkg.sv
  - cache_csr_pkg.sv
  - cache_lookup.sv
  - cache_access.sv
  - cache_wtbuf.sv
  - cache_control.sv
  - cache_top.sv
  - target: test
    files:
      - tb_cache_top.sv

/* tb_cache_top.sv */
/* testbench for the cache: clock, reset, memory model with
   random latency, checker, directed tests and watchdog */
`timescale 1ns/10ps
`default_nettype none

module tb_cache_top;
   import cache_pkg::*;
   import cache_csr_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int WORDS      = 2 ** (ADDR_W - BYTE_W);
   localparam int TEST_OPS   = 120;                 // cpu and register accesses, all tests
   localparam int WORST_CYC  = 4 * WTB_DEPTH + 12;  // drain, fetch and handshake
   localparam int HS_LIMIT   = 4 * WORST_CYC;
   localparam int TIMEOUT_NS = (TEST_OPS * WORST_CYC + 100) * CLK_PERIOD;

   logic                  clk_i, arst_i;
   logic                  cpu_valid_i, cpu_ready_o;
   logic [ADDR_W-1:0]     cpu_addr_i;
   logic [DATA_W-1:0]     cpu_wdata_i, cpu_rdata_o;
   logic [DATA_W/8-1:0]   cpu_wstrb_i;
   logic                  ctrl_valid_i, ctrl_ready_o;
   logic [CSR_ADDR_W-1:0] ctrl_addr_i;
   logic [DATA_W-1:0]     ctrl_wdata_i, ctrl_rdata_o;
   logic [DATA_W/8-1:0]   ctrl_wstrb_i;
   logic                  mem_rd_o, mem_rvalid_i, mem_wr_o, mem_wack_i;
   logic [ADDR_W-1:0]     mem_addr_o, mem_waddr_o;
   logic [DATA_W-1:0]     mem_rdata_i, mem_wdata_o;
   logic [DATA_W/8-1:0]   mem_wstrb_o;

   logic [DATA_W-1:0] mem_model [WORDS];  // written by the DUT's store drain
   logic [DATA_W-1:0] exp_mem [WORDS];    // expected contents, updated at issue
   logic              line_valid [LINES];
   logic [TAG_W-1:0]  line_tag [LINES];
   int                rd_hits, rd_misses, wr_hits, wr_misses;
   logic              ack_hold;           // withholds write acks
   logic [31:0]       lcg_state = 32'h4bf9_07d5;

   cache_top #(.LINES(LINES), .WTB_DEPTH(WTB_DEPTH), .USE_CTRL_CNT(1'b1)) dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [DATA_W-1:0] fill_word(input int w);
      return (DATA_W'(w) * 32'h0001_0003) ^ 32'h5ca1_ab1e;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
         input logic [DATA_W-1:0] new_w, input logic [DATA_W/8-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < DATA_W / 8; b++) begin
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   // memory read side, 1 to 4 cycles from mem_rd_o to rvalid
   initial begin
      int lat;
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
      forever begin
         @(posedge clk_i);
         #1;
         mem_rvalid_i = 1'b0;
         if (mem_rd_o === 1'b1) begin
            lat = 1 + (lcg_next() >> 16) % 4;
            repeat (lat - 1) begin
               @(posedge clk_i);
               #1;
            end
            mem_rdata_i  = mem_model[mem_addr_o[ADDR_W-1:BYTE_W]];
            mem_rvalid_i = 1'b1;
         end
      end
   end

   // memory write side, ack after 0 to 2 extra cycles
   initial begin
      int dly;
      logic [ADDR_W-BYTE_W-1:0] w;
      mem_wack_i = 1'b0;
      forever begin
         @(posedge clk_i);
         #1;
         mem_wack_i = 1'b0;
         if (mem_wr_o === 1'b1 && !ack_hold) begin
            dly = (lcg_next() >> 16) % 3;
            repeat (dly) begin
               @(posedge clk_i);
               #1;
            end
            if (!ack_hold) begin
               w            = mem_waddr_o[ADDR_W-1:BYTE_W];
               mem_model[w] = merge_bytes(mem_model[w], mem_wdata_o, mem_wstrb_o);
               mem_wack_i   = 1'b1;
            end
         end
      end
   end

   task automatic raise_error(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic compare(input string test, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         raise_error($sformatf("mismatch %s: expected %h, actual %h", test, exp, act));
      end
   endtask

   task automatic clear_lines();
      for (int i = 0; i < LINES; i++) line_valid[i] = 1'b0;
   endtask

   task automatic clear_tally();
      rd_hits   = 0;
      rd_misses = 0;
      wr_hits   = 0;
      wr_misses = 0;
   endtask

   // direct-mapped prediction, read misses allocate and writes never do
   task automatic issue_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                                input logic [DATA_W/8-1:0] strb);
      logic [IDX_W-1:0] idx;
      bit               hit;
      @(posedge clk_i);
      #1;  // idle cycle, lookup register free again
      idx = addr[BYTE_W +: IDX_W];
      hit = line_valid[idx] && (line_tag[idx] == addr[ADDR_W-1 -: TAG_W]);
      if (strb != '0) begin
         exp_mem[addr[ADDR_W-1:BYTE_W]] =
            merge_bytes(exp_mem[addr[ADDR_W-1:BYTE_W]], wdata, strb);
         if (hit) wr_hits++;
         else wr_misses++;
      end else if (hit) begin
         rd_hits++;
      end else begin
         rd_misses++;
         line_valid[idx] = 1'b1;
         line_tag[idx]   = addr[ADDR_W-1 -: TAG_W];
      end
      cpu_valid_i = 1'b1;
      cpu_addr_i  = addr;
      cpu_wdata_i = wdata;
      cpu_wstrb_i = strb;
   endtask

   task automatic await_ready(output logic [DATA_W-1:0] rdata, output int cycles);
      cycles = 0;
      while (cpu_ready_o !== 1'b1) begin
         @(posedge clk_i);
         #1;
         cycles++;
         if (cycles > HS_LIMIT) raise_error("cpu_ready_o never came for the pending request");
      end
      rdata       = cpu_rdata_o;
      cpu_valid_i = 1'b0;
      cpu_wstrb_i = '0;
   endtask

   task automatic read_word(input string test, input logic [ADDR_W-1:0] addr, output int cycles);
      logic [DATA_W-1:0] rdata;
      issue_request(addr, '0, '0);
      await_ready(rdata, cycles);
      compare(test, exp_mem[addr[ADDR_W-1:BYTE_W]], rdata);
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [DATA_W/8-1:0] strb, output int cycles);
      logic [DATA_W-1:0] rdata;
      issue_request(addr, wdata, strb);
      await_ready(rdata, cycles);
   endtask

   // one-cycle request, ready follows exactly one cycle later
   task automatic reg_access(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [DATA_W/8-1:0] strb, output logic [DATA_W-1:0] rdata);
      @(posedge clk_i);
      #1;  // last event pulse reaches the counters first
      ctrl_valid_i = 1'b1;
      ctrl_addr_i  = addr;
      ctrl_wdata_i = wdata;
      ctrl_wstrb_i = strb;
      @(posedge clk_i);
      #1;
      ctrl_valid_i = 1'b0;
      ctrl_wstrb_i = '0;
      if (ctrl_ready_o !== 1'b1) raise_error("ctrl_ready_o missing one cycle after the request");
      rdata = ctrl_rdata_o;
   endtask

   task automatic expect_reg(input string test, input logic [CSR_ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] rdata;
      reg_access(addr, '0, '0, rdata);
      compare(test, exp, rdata);
   endtask

   task automatic wait_drain(input string test);
      logic [DATA_W-1:0] rdata;
      int                tries;
      tries = 0;
      rdata = '0;
      while (rdata !== DATA_W'(1)) begin
         tries++;
         if (tries > HS_LIMIT) raise_error($sformatf("%s: write buffer never drained", test));
         reg_access(WTB_EMPTY_ADDR, '0, '0, rdata);
      end
   endtask

   task automatic check_counters(input string test);
      expect_reg($sformatf("%s read hit", test), READ_HIT_ADDR, rd_hits);
      expect_reg($sformatf("%s read miss", test), READ_MISS_ADDR, rd_misses);
      expect_reg($sformatf("%s write hit", test), WRITE_HIT_ADDR, wr_hits);
      expect_reg($sformatf("%s write miss", test), WRITE_MISS_ADDR, wr_misses);
      expect_reg($sformatf("%s rw hit", test), RW_HIT_ADDR, rd_hits + wr_hits);
      expect_reg($sformatf("%s rw miss", test), RW_MISS_ADDR, rd_misses + wr_misses);
   endtask

   task automatic read_miss_then_hit();
      int cycles;
      read_word("read miss", 16'h0040, cycles);
      read_word("read repeat", 16'h0040, cycles);
      compare("read hit cycles", 2, cycles);
      read_word("read miss other line", 16'h1044, cycles);
      read_word("read repeat other line", 16'h1044, cycles);
      compare("read hit cycles other line", 2, cycles);
   endtask

   task automatic write_merge();
      int cycles;
      write_word(16'h0040, 32'hdead_beef, 4'b0101, cycles);  // line present
      compare("write cycles", 2, cycles);
      read_word("write hit merge", 16'h0040, cycles);
      write_word(16'h2208, 32'h1234_5678, 4'b1100, cycles);  // no allocate
      read_word("write miss merge", 16'h2208, cycles);       // fetch after drain
      write_word(16'h2208, 32'h00ab_0000, 4'b0100, cycles);
      read_word("second merge", 16'h2208, cycles);
      wait_drain("write merge");
      compare("memory 0040", exp_mem[16'h0040 >> BYTE_W], mem_model[16'h0040 >> BYTE_W]);
      compare("memory 2208", exp_mem[16'h2208 >> BYTE_W], mem_model[16'h2208 >> BYTE_W]);
   endtask

   task automatic buffer_backpressure();
      logic [DATA_W-1:0] rdata;
      int                cycles;
      wait_drain("backpressure start");
      ack_hold = 1'b1;
      for (int k = 0; k < WTB_DEPTH; k++) begin
         write_word(ADDR_W'(16'h0300 + 4 * k), 32'h0a0b_0c00 + k, 4'b1111, cycles);
      end
      expect_reg("wtb full", WTB_FULL_ADDR, 1);
      issue_request(ADDR_W'(16'h0300 + 4 * WTB_DEPTH), 32'hfeed_f00d, 4'b1111);
      repeat (6) begin
         @(posedge clk_i);
         #1;
         compare("held write ready", 0, cpu_ready_o);
      end
      expect_reg("wtb still full", WTB_FULL_ADDR, 1);
      ack_hold = 1'b0;
      await_ready(rdata, cycles);
      wait_drain("backpressure end");
      expect_reg("wtb empty", WTB_EMPTY_ADDR, 1);
      expect_reg("wtb not full", WTB_FULL_ADDR, 0);
      for (int k = 0; k <= WTB_DEPTH; k++) begin
         compare("held store in memory", exp_mem[(16'h0300 >> BYTE_W) + k],
                 mem_model[(16'h0300 >> BYTE_W) + k]);
      end
   endtask

   task automatic counter_tally();
      logic [DATA_W-1:0]   rdata;
      logic [31:0]         r;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W/8-1:0] strb;
      int                  cycles;
      reg_access(RST_CNTRS_ADDR, 32'h1, 4'b0001, rdata);
      clear_tally();
      for (int k = 0; k < 40; k++) begin
         r    = lcg_next();
         addr = ADDR_W'(((r >> 8) % 48) * 4);  // 3 tags per line, mixed hits
         strb = r[27:24];
         if (r[20] && strb != '0) begin
            write_word(addr, lcg_next(), strb, cycles);
         end else begin
            read_word("random read", addr, cycles);
         end
      end
      check_counters("tally");
      reg_access(RST_CNTRS_ADDR, 32'h1, 4'b0001, rdata);
      clear_tally();
      check_counters("cleared");
   endtask

   task automatic invalidate_and_version();
      logic [DATA_W-1:0] rdata;
      int                cycles;
      read_word("prime line", 16'h0040, cycles);
      read_word("primed hit", 16'h0040, cycles);
      compare("primed hit cycles", 2, cycles);
      expect_reg("read miss before", READ_MISS_ADDR, rd_misses);
      reg_access(INVALIDATE_ADDR, 32'h0000_0100, 4'b0010, rdata);  // byte lane 1
      clear_lines();
      read_word("read after invalidate", 16'h0040, cycles);
      expect_reg("read miss after", READ_MISS_ADDR, rd_misses);
      expect_reg("version", VERSION_ADDR, CACHE_VERSION);
      expect_reg("unknown address", CSR_ADDR_W'(40), 0);
   endtask

   initial begin
      #(TIMEOUT_NS);
      raise_error("watchdog expired before the tests finished");
   end

   initial begin
      ack_hold     = 1'b0;
      arst_i       = 1'b1;
      cpu_valid_i  = 1'b0;
      cpu_addr_i   = '0;
      cpu_wdata_i  = '0;
      cpu_wstrb_i  = '0;
      ctrl_valid_i = 1'b0;
      ctrl_addr_i  = '0;
      ctrl_wdata_i = '0;
      ctrl_wstrb_i = '0;
      for (int w = 0; w < WORDS; w++) begin
         mem_model[w] = fill_word(w);
         exp_mem[w]   = fill_word(w);
      end
      clear_lines();
      clear_tally();
      repeat (2) @(posedge clk_i);
      #1;
      arst_i = 1'b0;
      read_miss_then_hit();
      write_merge();
      buffer_backpressure();
      counter_tally();
      invalidate_and_version();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* cache_top.sv */
/* cache top level: lookup, access and write buffer
   stages plus the control block */
`timescale 1ns/10ps
`default_nettype none

module cache_top #(
   parameter int LINES        = cache_pkg::LINES,
   parameter int WTB_DEPTH    = cache_pkg::WTB_DEPTH,
   parameter bit USE_CTRL_CNT = 1'b1
) (
   input  logic                                clk_i,
   input  logic                                arst_i,
   // processor port
   input  logic                                cpu_valid_i,
   input  logic [cache_pkg::ADDR_W-1:0]        cpu_addr_i,
   input  logic [cache_pkg::DATA_W-1:0]        cpu_wdata_i,
   input  logic [cache_pkg::DATA_W/8-1:0]      cpu_wstrb_i,
   output logic                                cpu_ready_o,
   output logic [cache_pkg::DATA_W-1:0]        cpu_rdata_o,
   // control port
   input  logic                                ctrl_valid_i,
   input  logic [cache_csr_pkg::CSR_ADDR_W-1:0] ctrl_addr_i,
   input  logic [cache_pkg::DATA_W-1:0]        ctrl_wdata_i,
   input  logic [cache_pkg::DATA_W/8-1:0]      ctrl_wstrb_i,
   output logic [cache_pkg::DATA_W-1:0]        ctrl_rdata_o,
   output logic                                ctrl_ready_o,
   // memory port
   output logic                                mem_rd_o,
   output logic [cache_pkg::ADDR_W-1:0]        mem_addr_o,
   input  logic                                mem_rvalid_i,
   input  logic [cache_pkg::DATA_W-1:0]        mem_rdata_i,
   output logic                                mem_wr_o,
   output logic [cache_pkg::ADDR_W-1:0]        mem_waddr_o,
   output logic [cache_pkg::DATA_W-1:0]        mem_wdata_o,
   output logic [cache_pkg::DATA_W/8-1:0]      mem_wstrb_o,
   input  logic                                mem_wack_i
);
   import cache_pkg::*;

   localparam int IW = $clog2(LINES);
   localparam int TW = ADDR_W - IW - BYTE_W;

   logic                lk_valid, lk_hit, lk_take;
   logic [ADDR_W-1:0]   lk_addr, push_addr;
   logic [DATA_W-1:0]   lk_wdata, push_data;
   logic [DATA_W/8-1:0] lk_wstrb, push_strb;
   logic                fill, push, wtb_full, wtb_empty, invalidate;
   logic [IW-1:0]       fill_idx;
   logic [TW-1:0]       fill_tag;
   logic                read_hit, read_miss, write_hit, write_miss;

   cache_lookup #(.LINES(LINES)) u_lookup (
      .clk_i, .arst_i, .cpu_valid_i, .cpu_addr_i, .cpu_wdata_i, .cpu_wstrb_i,
      .invalidate_i(invalidate), .fill_i(fill), .fill_idx_i(fill_idx),
      .fill_tag_i(fill_tag), .lk_take_i(lk_take), .lk_valid_o(lk_valid),
      .lk_hit_o(lk_hit), .lk_addr_o(lk_addr), .lk_wdata_o(lk_wdata), .lk_wstrb_o(lk_wstrb)
   );

   cache_access #(.LINES(LINES)) u_access (
      .clk_i, .arst_i, .lk_valid_i(lk_valid), .lk_hit_i(lk_hit), .lk_addr_i(lk_addr),
      .lk_wdata_i(lk_wdata), .lk_wstrb_i(lk_wstrb), .wtb_full_i(wtb_full),
      .wtb_empty_i(wtb_empty), .mem_rvalid_i, .mem_rdata_i, .lk_take_o(lk_take),
      .fill_o(fill), .fill_idx_o(fill_idx), .fill_tag_o(fill_tag), .push_o(push),
      .push_addr_o(push_addr), .push_data_o(push_data), .push_strb_o(push_strb),
      .mem_rd_o, .mem_addr_o, .cpu_ready_o, .cpu_rdata_o, .read_hit_o(read_hit),
      .read_miss_o(read_miss), .write_hit_o(write_hit), .write_miss_o(write_miss)
   );

   cache_wtbuf #(.WTB_DEPTH(WTB_DEPTH)) u_wtbuf (
      .clk_i, .arst_i, .push_i(push), .push_addr_i(push_addr), .push_data_i(push_data),
      .push_strb_i(push_strb), .mem_wack_i, .mem_wr_o, .mem_waddr_o, .mem_wdata_o,
      .mem_wstrb_o, .wtb_empty_o(wtb_empty), .wtb_full_o(wtb_full)
   );

   cache_control #(.USE_CTRL_CNT(USE_CTRL_CNT)) u_control (
      .clk_i, .arst_i, .ctrl_valid_i, .ctrl_addr_i, .ctrl_wdata_i, .ctrl_wstrb_i,
      .read_hit_i(read_hit), .read_miss_i(read_miss), .write_hit_i(write_hit),
      .write_miss_i(write_miss), .wtbuf_empty_i(wtb_empty), .wtbuf_full_i(wtb_full),
      .ctrl_rdata_o, .ctrl_ready_o, .invalidate_o(invalidate)
   );

endmodule

`default_nettype wire

/* cache_control.sv */
/* control registers: decode, strobe priority encode,
   optional event counters and invalidate strobe */
`timescale 1ns/10ps
`default_nettype none

module cache_control #(
   parameter bit USE_CTRL_CNT = 1'b1
) (
   input  logic                                clk_i,
   input  logic                                arst_i,
   input  logic                                ctrl_valid_i,
   input  logic [cache_csr_pkg::CSR_ADDR_W-1:0] ctrl_addr_i,
   input  logic [cache_pkg::DATA_W-1:0]        ctrl_wdata_i,
   input  logic [cache_pkg::DATA_W/8-1:0]      ctrl_wstrb_i,
   input  logic                                read_hit_i,
   input  logic                                read_miss_i,
   input  logic                                write_hit_i,
   input  logic                                write_miss_i,
   input  logic                                wtbuf_empty_i,
   input  logic                                wtbuf_full_i,
   output logic [cache_pkg::DATA_W-1:0]        ctrl_rdata_o,
   output logic                                ctrl_ready_o,
   output logic                                invalidate_o
);
   import cache_pkg::*;
   import cache_csr_pkg::*;

   logic [BYTE_W-1:0]     byte_offset;
   logic [CSR_ADDR_W-1:0] wr_addr;
   logic                  is_wr;
   logic                  is_rd;
   logic [DATA_W-1:0]     rd_mux;
   logic [DATA_W-1:0]     cnt_rdata;

   // lowest set strobe bit gives the byte lane
   always_comb begin
      byte_offset = '0;
      for (int i = DATA_W / 8 - 1; i >= 0; i--) begin
         if (ctrl_wstrb_i[i]) byte_offset = BYTE_W'(i);
      end
   end

   assign is_wr   = ctrl_valid_i && (ctrl_wstrb_i != '0);
   assign is_rd   = ctrl_valid_i && (ctrl_wstrb_i == '0);
   assign wr_addr = {ctrl_addr_i[CSR_ADDR_W-1:BYTE_W], byte_offset};

   always_comb begin
      case (ctrl_addr_i)
         WTB_EMPTY_ADDR: rd_mux = DATA_W'(wtbuf_empty_i);
         WTB_FULL_ADDR:  rd_mux = DATA_W'(wtbuf_full_i);
         VERSION_ADDR:   rd_mux = DATA_W'(CACHE_VERSION);
         default:        rd_mux = cnt_rdata;  // zero for unknown addresses
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         ctrl_ready_o <= 1'b0;
         invalidate_o <= 1'b0;
         ctrl_rdata_o <= '0;
      end else begin
         ctrl_ready_o <= ctrl_valid_i;  // fixed one-cycle answer
         invalidate_o <= is_wr && (wr_addr == INVALIDATE_ADDR);
         ctrl_rdata_o <= is_rd ? rd_mux : '0;
      end
   end

   generate
      if (USE_CTRL_CNT) begin : g_cnt
         logic [DATA_W-1:0] rh_cnt;
         logic [DATA_W-1:0] rm_cnt;
         logic [DATA_W-1:0] wh_cnt;
         logic [DATA_W-1:0] wm_cnt;
         logic              clr;

         assign clr = is_wr && (wr_addr == RST_CNTRS_ADDR);

         always_ff @(posedge clk_i or posedge arst_i) begin
            if (arst_i) begin
               rh_cnt <= '0;
               rm_cnt <= '0;
               wh_cnt <= '0;
               wm_cnt <= '0;
            end else if (clr) begin
               rh_cnt <= '0;
               rm_cnt <= '0;
               wh_cnt <= '0;
               wm_cnt <= '0;
            end else begin
               if (read_hit_i) rh_cnt <= rh_cnt + 1'b1;
               if (read_miss_i) rm_cnt <= rm_cnt + 1'b1;
               if (write_hit_i) wh_cnt <= wh_cnt + 1'b1;
               if (write_miss_i) wm_cnt <= wm_cnt + 1'b1;
            end
         end

         // sums straight from the live counters
         always_comb begin
            case (ctrl_addr_i)
               RW_HIT_ADDR:     cnt_rdata = rh_cnt + wh_cnt;
               RW_MISS_ADDR:    cnt_rdata = rm_cnt + wm_cnt;
               READ_HIT_ADDR:   cnt_rdata = rh_cnt;
               READ_MISS_ADDR:  cnt_rdata = rm_cnt;
               WRITE_HIT_ADDR:  cnt_rdata = wh_cnt;
               WRITE_MISS_ADDR: cnt_rdata = wm_cnt;
               default:         cnt_rdata = '0;
            endcase
         end
      end else begin : g_no_cnt
         assign cnt_rdata = '0;
      end
   endgenerate

endmodule

`default_nettype wire

/* cache_wtbuf.sv */
/* write-through buffer: circular FIFO of stores,
   drained to memory oldest first */
`timescale 1ns/10ps
`default_nettype none

module cache_wtbuf #(
   parameter int  WTB_DEPTH = cache_pkg::WTB_DEPTH,
   localparam int PW        = (WTB_DEPTH > 1) ? $clog2(WTB_DEPTH) : 1,
   localparam int CW        = $clog2(WTB_DEPTH + 1)
) (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           push_i,
   input  logic [cache_pkg::ADDR_W-1:0]   push_addr_i,
   input  logic [cache_pkg::DATA_W-1:0]   push_data_i,
   input  logic [cache_pkg::DATA_W/8-1:0] push_strb_i,
   input  logic                           mem_wack_i,
   output logic                           mem_wr_o,
   output logic [cache_pkg::ADDR_W-1:0]   mem_waddr_o,
   output logic [cache_pkg::DATA_W-1:0]   mem_wdata_o,
   output logic [cache_pkg::DATA_W/8-1:0] mem_wstrb_o,
   output logic                           wtb_empty_o,
   output logic                           wtb_full_o
);
   import cache_pkg::*;

   logic [ADDR_W-1:0]   addr_mem [WTB_DEPTH];
   logic [DATA_W-1:0]   data_mem [WTB_DEPTH];
   logic [DATA_W/8-1:0] strb_mem [WTB_DEPTH];
   logic [PW-1:0]       wr_ptr;
   logic [PW-1:0]       rd_ptr;
   logic [CW-1:0]       count;
   logic                do_push;
   logic                do_pop;

   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
      return (p == PW'(WTB_DEPTH - 1)) ? '0 : p + 1'b1;  // depth need not be 2^n
   endfunction

   assign do_push     = push_i && !wtb_full_o;
   assign do_pop      = mem_wack_i && mem_wr_o;
   assign wtb_empty_o = (count == '0);
   assign wtb_full_o  = (count == CW'(WTB_DEPTH));
   assign mem_wr_o    = !wtb_empty_o;  // head shown while non-empty
   assign mem_waddr_o = addr_mem[rd_ptr];
   assign mem_wdata_o = data_mem[rd_ptr];
   assign mem_wstrb_o = strb_mem[rd_ptr];

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop) rd_ptr <= next_ptr(rd_ptr);
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         addr_mem[wr_ptr] <= push_addr_i;
         data_mem[wr_ptr] <= push_data_i;
         strb_mem[wr_ptr] <= push_strb_i;
      end
   end

   a_wack_in_write: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_wack_i |-> mem_wr_o);

endmodule

`default_nettype wire

/* cache_access.sv */
/* access stage: data array, refill FSM, processor
   response, store push and hit/miss event pulses */
`timescale 1ns/10ps
`default_nettype none

module cache_access #(
   parameter int  LINES = cache_pkg::LINES,
   localparam int IW    = $clog2(LINES),
   localparam int TW    = cache_pkg::ADDR_W - IW - cache_pkg::BYTE_W
) (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           lk_valid_i,
   input  logic                           lk_hit_i,
   input  logic [cache_pkg::ADDR_W-1:0]   lk_addr_i,
   input  logic [cache_pkg::DATA_W-1:0]   lk_wdata_i,
   input  logic [cache_pkg::DATA_W/8-1:0] lk_wstrb_i,
   input  logic                           wtb_full_i,
   input  logic                           wtb_empty_i,
   input  logic                           mem_rvalid_i,
   input  logic [cache_pkg::DATA_W-1:0]   mem_rdata_i,
   output logic                           lk_take_o,
   output logic                           fill_o,
   output logic [IW-1:0]                  fill_idx_o,
   output logic [TW-1:0]                  fill_tag_o,
   output logic                           push_o,
   output logic [cache_pkg::ADDR_W-1:0]   push_addr_o,
   output logic [cache_pkg::DATA_W-1:0]   push_data_o,
   output logic [cache_pkg::DATA_W/8-1:0] push_strb_o,
   output logic                           mem_rd_o,
   output logic [cache_pkg::ADDR_W-1:0]   mem_addr_o,
   output logic                           cpu_ready_o,
   output logic [cache_pkg::DATA_W-1:0]   cpu_rdata_o,
   output logic                           read_hit_o,
   output logic                           read_miss_o,
   output logic                           write_hit_o,
   output logic                           write_miss_o
);
   import cache_pkg::*;

   typedef enum logic [1:0] {st_serve, st_wait_empty, st_fetch} state_e;

   state_e            state_q;
   logic [DATA_W-1:0] data_mem [LINES];
   logic [IW-1:0]     idx;
   logic              is_read;
   logic              rd_hit;
   logic              wr_go;
   logic              fetch_done;

   assign idx        = lk_addr_i[BYTE_W +: IW];
   assign is_read    = (lk_wstrb_i == '0);
   assign rd_hit     = (state_q == st_serve) && lk_valid_i && is_read && lk_hit_i;
   assign wr_go      = (state_q == st_serve) && lk_valid_i && !is_read && !wtb_full_i;
   assign fetch_done = (state_q == st_fetch) && mem_rvalid_i;

   assign lk_take_o  = rd_hit || wr_go || fetch_done;
   assign fill_o     = fetch_done;
   assign fill_idx_o = idx;
   assign fill_tag_o = lk_addr_i[ADDR_W-1 -: TW];
   assign mem_rd_o   = (state_q == st_fetch);  // held until rvalid
   assign mem_addr_o = lk_addr_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q      <= st_serve;
         cpu_ready_o  <= 1'b0;
         push_o       <= 1'b0;
         read_hit_o   <= 1'b0;
         read_miss_o  <= 1'b0;
         write_hit_o  <= 1'b0;
         write_miss_o <= 1'b0;
      end else begin
         cpu_ready_o  <= lk_take_o;
         push_o       <= wr_go;  // lands with the ready pulse
         read_hit_o   <= rd_hit;
         read_miss_o  <= fetch_done;
         write_hit_o  <= wr_go && lk_hit_i;
         write_miss_o <= wr_go && !lk_hit_i;
         case (state_q)
            st_serve: begin
               if (lk_valid_i && is_read && !lk_hit_i) state_q <= st_wait_empty;
            end
            st_wait_empty: begin
               if (wtb_empty_i) state_q <= st_fetch;  // earlier stores reached memory
            end
            st_fetch: begin
               if (mem_rvalid_i) state_q <= st_serve;
            end
            default: state_q <= st_serve;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_hit) begin
         cpu_rdata_o <= data_mem[idx];
      end else if (fetch_done) begin
         cpu_rdata_o <= mem_rdata_i;
      end
      if (fetch_done) begin
         data_mem[idx] <= mem_rdata_i;
      end else if (wr_go && lk_hit_i) begin
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (lk_wstrb_i[b]) data_mem[idx][8*b +: 8] <= lk_wdata_i[8*b +: 8];
         end
      end
      if (wr_go) begin
         push_addr_o <= lk_addr_i;
         push_data_o <= lk_wdata_i;
         push_strb_o <= lk_wstrb_i;
      end
   end

   a_no_push_full: assert property (@(posedge clk_i) disable iff (arst_i)
      push_o |-> !wtb_full_i);

endmodule

`default_nettype wire

/* cache_lookup.sv */
/* tag lookup stage: tag and valid arrays, request register,
   hit detection and whole-cache invalidate */
`timescale 1ns/10ps
`default_nettype none

module cache_lookup #(
   parameter int  LINES = cache_pkg::LINES,
   localparam int IW    = $clog2(LINES),
   localparam int TW    = cache_pkg::ADDR_W - IW - cache_pkg::BYTE_W
) (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           cpu_valid_i,
   input  logic [cache_pkg::ADDR_W-1:0]   cpu_addr_i,
   input  logic [cache_pkg::DATA_W-1:0]   cpu_wdata_i,
   input  logic [cache_pkg::DATA_W/8-1:0] cpu_wstrb_i,
   input  logic                           invalidate_i,
   input  logic                           fill_i,
   input  logic [IW-1:0]                  fill_idx_i,
   input  logic [TW-1:0]                  fill_tag_i,
   input  logic                           lk_take_i,
   output logic                           lk_valid_o,
   output logic                           lk_hit_o,
   output logic [cache_pkg::ADDR_W-1:0]   lk_addr_o,
   output logic [cache_pkg::DATA_W-1:0]   lk_wdata_o,
   output logic [cache_pkg::DATA_W/8-1:0] lk_wstrb_o
);
   import cache_pkg::*;

   logic [TW-1:0]    tag_mem [LINES];
   logic [LINES-1:0] valid_q;
   logic             taken_q;  // high in the ready cycle of the last request
   logic             accept;
   logic [IW-1:0]    idx;

   // the requester still holds its old request during the ready cycle
   assign accept   = cpu_valid_i && !lk_valid_o && !taken_q;
   assign idx      = lk_addr_o[BYTE_W +: IW];
   assign lk_hit_o = valid_q[idx] && (tag_mem[idx] == lk_addr_o[ADDR_W-1 -: TW]);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         lk_valid_o <= 1'b0;
         taken_q    <= 1'b0;
      end else begin
         taken_q <= lk_take_i;
         if (lk_take_i) begin
            lk_valid_o <= 1'b0;
         end else if (accept) begin
            lk_valid_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         lk_addr_o  <= cpu_addr_i;
         lk_wdata_o <= cpu_wdata_i;
         lk_wstrb_o <= cpu_wstrb_i;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;  // all lines at once
      end else if (fill_i) begin
         valid_q[fill_idx_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_i) tag_mem[fill_idx_i] <= fill_tag_i;
   end

   // control block and refill never collide
   a_no_inv_fill: assert property (@(posedge clk_i) disable iff (arst_i)
      !(invalidate_i && fill_i));

endmodule

`default_nettype wire

/* cache_csr_pkg.sv */
/* control register map: address width, register
   byte addresses and the version word */
`default_nettype none

package cache_csr_pkg;

   localparam int CSR_ADDR_W = 6;

   // read-only registers, one per word
   localparam logic [CSR_ADDR_W-1:0] RW_HIT_ADDR     = 'd0;
   localparam logic [CSR_ADDR_W-1:0] RW_MISS_ADDR    = 'd4;
   localparam logic [CSR_ADDR_W-1:0] READ_HIT_ADDR   = 'd8;
   localparam logic [CSR_ADDR_W-1:0] READ_MISS_ADDR  = 'd12;
   localparam logic [CSR_ADDR_W-1:0] WRITE_HIT_ADDR  = 'd16;
   localparam logic [CSR_ADDR_W-1:0] WRITE_MISS_ADDR = 'd20;
   localparam logic [CSR_ADDR_W-1:0] WTB_EMPTY_ADDR  = 'd24;
   localparam logic [CSR_ADDR_W-1:0] WTB_FULL_ADDR   = 'd28;
   localparam logic [CSR_ADDR_W-1:0] VERSION_ADDR    = 'd32;

   // write-only strobes, byte addressed within one word
   localparam logic [CSR_ADDR_W-1:0] RST_CNTRS_ADDR  = 'd36;
   localparam logic [CSR_ADDR_W-1:0] INVALIDATE_ADDR = 'd37;

   localparam logic [15:0] CACHE_VERSION = 16'h0110;

endpackage

`default_nettype wire

/* cache_pkg.sv */
/* cache geometry: address and data widths, line count,
   derived index and tag widths, write buffer depth */
`default_nettype none

package cache_pkg;

   localparam int ADDR_W    = 16;  // byte address
   localparam int DATA_W    = 32;
   localparam int LINES     = 16;
   localparam int BYTE_W    = $clog2(DATA_W / 8);  // byte offset bits
   localparam int IDX_W     = $clog2(LINES);
   localparam int TAG_W     = ADDR_W - IDX_W - BYTE_W;
   localparam int WTB_DEPTH = 4;  // write-through buffer entries

endpackage

`default_nettype wire
